/* hw/isaPkg.sv */
package isaPkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regIdx_t;

    // Primary opcodes of the supported subset
    typedef enum logic [5:0] {
        opSpecial = 6'h00,
        opJ       = 6'h02,
        opJal     = 6'h03,
        opBeq     = 6'h04,
        opBne     = 6'h05,
        opAddiu   = 6'h09,
        opOri     = 6'h0d,
        opLui     = 6'h0f,
        opLw      = 6'h23,
        opSw      = 6'h2b
    } opcode_t;

    // Function field under opSpecial
    typedef enum logic [5:0] {
        fnJr   = 6'h08,
        fnAddu = 6'h21,
        fnSubu = 6'h23,
        fnAnd  = 6'h24,
        fnOr   = 6'h25,
        fnSlt  = 6'h2a
    } funct_t;

    localparam regIdx_t linkReg = 5'd31;

    function automatic opcode_t opcodeOf(word_t inst);
        return opcode_t'(inst[31:26]);
    endfunction

    function automatic funct_t functOf(word_t inst);
        return funct_t'(inst[5:0]);
    endfunction

    function automatic regIdx_t rsOf(word_t inst);
        return inst[25:21];
    endfunction

    function automatic regIdx_t rtOf(word_t inst);
        return inst[20:16];
    endfunction

    function automatic regIdx_t rdOf(word_t inst);
        return inst[15:11];
    endfunction

    function automatic logic [15:0] immOf(word_t inst);
        return inst[15:0];
    endfunction

    function automatic logic [25:0] targetOf(word_t inst);
        return inst[25:0];
    endfunction

endpackage

/* hw/pipePkg.sv */
package pipePkg;

    // Operation carried out by the decode-stage ALU
    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt,
        aluLui,
        aluPass
    } aluOp_t;

    // Where the register write value comes from
    typedef enum logic [1:0] {
        wbNone,
        wbAlu,
        wbLink,
        wbMem
    } wbSrc_t;

    // How the PC continues after the delay slot
    typedef enum logic [2:0] {
        pcSeq,
        pcBeq,
        pcBne,
        pcJumpImm,
        pcJumpReg
    } nextPc_t;

endpackage

/* hw/fetchUnit.sv */
`timescale 1ns/1ps

module fetchUnit import isaPkg::*; #(
    parameter word_t resetPc = 32'h0000_0000
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  stall,
    input  logic  redirect,
    input  word_t redirectPc,
    input  word_t instData,
    input  logic  instValid,
    output word_t instAddr,
    output logic  instReq,
    output logic  fetchValid,
    output word_t fetchInst,
    output word_t fetchPc
);

    word_t pc;
    word_t bufInst;
    word_t bufPc;
    word_t pendPc;
    logic  bufValid;
    logic  pendValid;
    logic  accept;
    logic  slotTaken;

    // No new request while an instruction waits in the buffer
    assign instReq  = !bufValid;
    assign instAddr = pc;
    assign accept   = instReq && instValid;

    assign fetchValid = bufValid || accept;
    assign fetchInst  = bufValid ? bufInst : instData;
    assign fetchPc    = bufValid ? bufPc : pc;

    // Delay slot already fetched when decode resolves the jump
    assign slotTaken = accept || bufValid;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc        <= resetPc;
            bufValid  <= 1'b0;
            pendValid <= 1'b0;
        end else begin
            if (!stall) begin
                bufValid <= 1'b0;
            end else if (accept) begin
                bufValid <= 1'b1;
            end

            if (redirect && slotTaken) begin
                pc <= redirectPc;
            end else if (accept && pendValid) begin
                pc <= pendPc;
            end else if (accept) begin
                pc <= pc + 32'd4;
            end

            // Delay slot still in flight, jump once it lands
            if (redirect && !slotTaken) begin
                pendValid <= 1'b1;
            end else if (accept) begin
                pendValid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && stall) begin
            bufInst <= instData;
            bufPc   <= pc;
        end
        if (redirect) begin
            pendPc <= redirectPc;
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        instReq && !instValid |=> instReq && $stable(instAddr));

endmodule

/* hw/decodeStage.sv */
`timescale 1ns/1ps

module decodeStage import isaPkg::*, pipePkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    stall,
    input  logic    flushOut,
    input  logic    fetchValid,
    input  word_t   fetchInst,
    input  word_t   fetchPc,
    input  word_t   opValue0,
    input  word_t   opValue1,
    input  logic    opWait0,
    input  logic    opWait1,
    output regIdx_t readReg0,
    output regIdx_t readReg1,
    output logic    needOp0,
    output logic    needOp1,
    output logic    redirect,
    output word_t   redirectPc,
    output logic    decValid,
    output regIdx_t decDest,
    output wbSrc_t  decWbSrc,
    output word_t   decAluResult,
    output word_t   decMemAddr,
    output word_t   decStoreData,
    output logic    decLoad,
    output logic    decStore,
    output word_t   decPc
);

    logic    dValid;
    word_t   dInst;
    word_t   dPc;
    aluOp_t  aluOp;
    nextPc_t nextKind;
    logic    useImm;
    logic    zeroImm;
    logic    use0;
    logic    use1;
    logic    taken;
    logic    decodeStall;
    logic    issue;
    word_t   signImm;
    word_t   opB;
    word_t   slotPc;

    always_ff @(posedge clk) begin
        if (reset) begin
            dValid <= 1'b0;
        end else if (!stall) begin
            dValid <= fetchValid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            dInst <= fetchInst;
            dPc   <= fetchPc;
        end
    end

    assign readReg0 = rsOf(dInst);
    assign readReg1 = rtOf(dInst);

    // Anything outside the subset falls through as a no-op
    always_comb begin
        aluOp    = aluPass;
        nextKind = pcSeq;
        useImm   = 1'b0;
        zeroImm  = 1'b0;
        use0     = 1'b0;
        use1     = 1'b0;
        decDest  = '0;
        decWbSrc = wbNone;
        decLoad  = 1'b0;
        decStore = 1'b0;
        case (opcodeOf(dInst))
            opSpecial: begin
                case (functOf(dInst))
                    fnJr: begin
                        nextKind = pcJumpReg;
                        use0     = 1'b1;
                    end
                    fnAddu:  aluOp = aluAdd;
                    fnSubu:  aluOp = aluSub;
                    fnAnd:   aluOp = aluAnd;
                    fnOr:    aluOp = aluOr;
                    fnSlt:   aluOp = aluSlt;
                    default: aluOp = aluPass;
                endcase
                if (aluOp != aluPass) begin
                    use0     = 1'b1;
                    use1     = 1'b1;
                    decDest  = rdOf(dInst);
                    decWbSrc = wbAlu;
                end
            end
            opJ: nextKind = pcJumpImm;
            opJal: begin
                nextKind = pcJumpImm;
                decDest  = linkReg;
                decWbSrc = wbLink;
            end
            opBeq, opBne: begin
                nextKind = (opcodeOf(dInst) == opBeq) ? pcBeq : pcBne;
                use0     = 1'b1;
                use1     = 1'b1;
            end
            opAddiu, opOri, opLui: begin
                aluOp    = (opcodeOf(dInst) == opAddiu) ? aluAdd :
                           (opcodeOf(dInst) == opOri) ? aluOr : aluLui;
                zeroImm  = opcodeOf(dInst) == opOri;
                useImm   = 1'b1;
                use0     = opcodeOf(dInst) != opLui;
                decDest  = rtOf(dInst);
                decWbSrc = wbAlu;
            end
            opLw: begin
                decLoad  = 1'b1;
                use0     = 1'b1;
                decDest  = rtOf(dInst);
                decWbSrc = wbMem;
            end
            opSw: begin
                decStore = 1'b1;
                use0     = 1'b1;
                use1     = 1'b1;
            end
            default: nextKind = pcSeq;
        endcase
    end

    assign signImm = {{16{dInst[15]}}, immOf(dInst)};
    assign opB     = !useImm ? opValue1 : zeroImm ? {16'b0, immOf(dInst)} : signImm;

    always_comb begin
        case (aluOp)
            aluAdd:  decAluResult = opValue0 + opB;
            aluSub:  decAluResult = opValue0 - opB;
            aluAnd:  decAluResult = opValue0 & opB;
            aluOr:   decAluResult = opValue0 | opB;
            aluSlt:  decAluResult = {31'b0, $signed(opValue0) < $signed(opB)};
            aluLui:  decAluResult = {immOf(dInst), 16'b0};
            default: decAluResult = opB;
        endcase
    end

    // Branch compare runs on forwarded operands
    always_comb begin
        case (nextKind)
            pcBeq:                taken = opValue0 == opValue1;
            pcBne:                taken = opValue0 != opValue1;
            pcJumpImm, pcJumpReg: taken = 1'b1;
            default:              taken = 1'b0;
        endcase
    end

    assign slotPc     = dPc + 32'd4;
    assign redirectPc = (nextKind == pcJumpReg) ? opValue0 :
                        (nextKind == pcJumpImm) ? {slotPc[31:28], targetOf(dInst), 2'b00} :
                        slotPc + {signImm[29:0], 2'b00};

    assign needOp0     = dValid && use0;
    assign needOp1     = dValid && use1;
    assign decodeStall = (needOp0 && opWait0) || (needOp1 && opWait1);

    // Leaves decode only when operands are ready and memory is not holding
    assign issue    = dValid && !decodeStall && !flushOut;
    assign redirect = issue && taken;

    assign decValid     = issue;
    assign decMemAddr   = opValue0 + signImm;
    assign decStoreData = opValue1;
    assign decPc        = dPc;

endmodule

/* hw/regFile.sv */
`timescale 1ns/1ps

module regFile import isaPkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  regIdx_t readReg0,
    input  regIdx_t readReg1,
    input  regIdx_t writeReg,
    input  word_t   writeData,
    input  logic    writeEn,
    output word_t   readData0,
    output word_t   readData1
);

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (writeEn) begin
            regs[writeReg] <= writeData;
        end
    end

    // Write in the same cycle bypasses the array
    assign readData0 = (readReg0 == '0) ? '0 :
                       (writeEn && writeReg == readReg0) ? writeData : regs[readReg0];
    assign readData1 = (readReg1 == '0) ? '0 :
                       (writeEn && writeReg == readReg1) ? writeData : regs[readReg1];

    // Writeback must filter out r0 targets
    assert property (@(posedge clk) disable iff (reset)
        writeEn |-> writeReg != '0);

endmodule

/* hw/operandForward.sv */
`timescale 1ns/1ps

module operandForward import isaPkg::*; (
    input  regIdx_t reqReg,
    input  logic    needed,
    input  word_t   rfValue,
    input  logic    exeFwdValid,
    input  regIdx_t exeFwdReg,
    input  word_t   exeFwdValue,
    input  logic    exeIsLoad,
    input  logic    wbFwdValid,
    input  regIdx_t wbFwdReg,
    input  word_t   wbFwdValue,
    output word_t   opValue,
    output logic    opWait
);

    logic exeHit;
    logic wbHit;

    assign exeHit = reqReg != '0 && exeFwdReg == reqReg;
    assign wbHit  = reqReg != '0 && wbFwdValid && wbFwdReg == reqReg;

    // Execute holds the younger value
    always_comb begin
        if (exeHit && exeFwdValid) begin
            opValue = exeFwdValue;
        end else if (wbHit) begin
            opValue = wbFwdValue;
        end else begin
            opValue = rfValue;
        end
    end

    // Load data not back yet
    assign opWait = needed && exeHit && exeIsLoad;

endmodule

/* hw/executeStage.sv */
`timescale 1ns/1ps

module executeStage import isaPkg::*, pipePkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    stall,
    input  logic    decValid,
    input  regIdx_t decDest,
    input  wbSrc_t  decWbSrc,
    input  word_t   decAluResult,
    input  word_t   decMemAddr,
    input  word_t   decStoreData,
    input  logic    decLoad,
    input  logic    decStore,
    input  word_t   decPc,
    input  word_t   dataRdata,
    input  logic    dataValid,
    output word_t   dataAddr,
    output logic    dataRead,
    output logic    dataWrite,
    output word_t   dataWdata,
    output logic    memStall,
    output logic    exeFwdValid,
    output regIdx_t exeFwdReg,
    output word_t   exeFwdValue,
    output logic    exeIsLoad,
    output logic    exeValid,
    output regIdx_t exeDest,
    output wbSrc_t  exeWbSrc,
    output word_t   exeAluResult,
    output word_t   exePc,
    output word_t   exeLoadData
);

    logic  exeFull;
    logic  exeLoad;
    logic  exeStore;
    word_t exeMemAddr;
    word_t exeStoreData;

    always_ff @(posedge clk) begin
        if (reset) begin
            exeFull <= 1'b0;
        end else if (!stall) begin
            exeFull <= decValid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            exeDest      <= decDest;
            exeWbSrc     <= decWbSrc;
            exeAluResult <= decAluResult;
            exeMemAddr   <= decMemAddr;
            exeStoreData <= decStoreData;
            exeLoad      <= decLoad;
            exeStore     <= decStore;
            exePc        <= decPc;
        end
    end

    // Request stays up until the memory answers
    assign dataRead  = exeFull && exeLoad;
    assign dataWrite = exeFull && exeStore;
    assign dataAddr  = exeMemAddr;
    assign dataWdata = exeStoreData;
    assign memStall  = (dataRead || dataWrite) && !dataValid;

    // Sampled by writeback at the end of the valid cycle
    assign exeLoadData = dataRdata;
    assign exeValid    = exeFull && !memStall;

    assign exeFwdReg   = exeDest;
    assign exeFwdValid = exeFull && !exeLoad && exeDest != '0;
    assign exeFwdValue = (exeWbSrc == wbLink) ? exePc + 32'd8 : exeAluResult;
    assign exeIsLoad   = exeFull && exeLoad;

    assert property (@(posedge clk) disable iff (reset)
        !(dataRead && dataWrite));

    assert property (@(posedge clk) disable iff (reset)
        (dataRead || dataWrite) && !dataValid |=>
            (dataRead || dataWrite) && $stable(dataAddr));

endmodule

/* hw/writebackStage.sv */
`timescale 1ns/1ps

module writebackStage import isaPkg::*, pipePkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    exeValid,
    input  regIdx_t exeDest,
    input  wbSrc_t  exeWbSrc,
    input  word_t   exeAluResult,
    input  word_t   exePc,
    input  word_t   exeLoadData,
    output regIdx_t writeReg,
    output word_t   writeData,
    output logic    writeEn,
    output logic    wbFwdValid,
    output regIdx_t wbFwdReg,
    output word_t   wbFwdValue,
    output word_t   wbPc,
    output logic    wbWen,
    output regIdx_t wbWnum,
    output word_t   wbWdata
);

    logic    wbValid;
    regIdx_t dest;
    wbSrc_t  src;
    word_t   aluResult;
    word_t   loadData;
    word_t   value;

    always_ff @(posedge clk) begin
        if (reset) begin
            wbValid <= 1'b0;
        end else begin
            wbValid <= exeValid;
        end
    end

    always_ff @(posedge clk) begin
        if (exeValid) begin
            dest      <= exeDest;
            src       <= exeWbSrc;
            aluResult <= exeAluResult;
            loadData  <= exeLoadData;
            wbPc      <= exePc;
        end
    end

    always_comb begin
        case (src)
            wbMem:   value = loadData;
            wbLink:  value = wbPc + 32'd8;
            default: value = aluResult;
        endcase
    end

    // Only instructions with a nonzero destination carry one
    assign writeEn   = wbValid && dest != '0;
    assign writeReg  = dest;
    assign writeData = value;

    assign wbFwdValid = writeEn;
    assign wbFwdReg   = dest;
    assign wbFwdValue = value;

    // Debug trace
    assign wbWen   = writeEn;
    assign wbWnum  = dest;
    assign wbWdata = value;

endmodule

/* hw/mipsCore.sv */
`timescale 1ns/1ps

module mipsCore import isaPkg::*, pipePkg::*; #(
    parameter word_t resetPc = 32'h0000_0000
) (
    input  logic    clk,
    input  logic    reset,
    output word_t   instAddr,
    output logic    instReq,
    input  word_t   instData,
    input  logic    instValid,
    output word_t   dataAddr,
    output logic    dataRead,
    output logic    dataWrite,
    output word_t   dataWdata,
    input  word_t   dataRdata,
    input  logic    dataValid,
    output word_t   wbPc,
    output logic    wbWen,
    output regIdx_t wbWnum,
    output word_t   wbWdata
);

    logic    fetchValid;
    word_t   fetchInst;
    word_t   fetchPc;
    logic    redirect;
    word_t   redirectPc;
    logic    decValid;
    regIdx_t decDest;
    wbSrc_t  decWbSrc;
    word_t   decAluResult;
    word_t   decMemAddr;
    word_t   decStoreData;
    logic    decLoad;
    logic    decStore;
    word_t   decPc;
    logic    memStall;
    logic    exeFwdValid;
    regIdx_t exeFwdReg;
    word_t   exeFwdValue;
    logic    exeIsLoad;
    logic    exeValid;
    regIdx_t exeDest;
    wbSrc_t  exeWbSrc;
    word_t   exeAluResult;
    word_t   exePc;
    word_t   exeLoadData;
    regIdx_t writeReg;
    word_t   writeData;
    logic    writeEn;
    logic    wbFwdValid;
    regIdx_t wbFwdReg;
    word_t   wbFwdValue;
    logic    decodeStall;
    logic    frontStall;

    // One entry per source operand
    regIdx_t readReg [2];
    word_t   rfData [2];
    word_t   opValue [2];
    logic    needOp [2];
    logic    opWait [2];

    assign decodeStall = opWait[0] || opWait[1];
    assign frontStall  = memStall || decodeStall;

    fetchUnit #(.resetPc(resetPc)) u_fetch (
        .clk        (clk),
        .reset      (reset),
        .stall      (frontStall),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .instData   (instData),
        .instValid  (instValid),
        .instAddr   (instAddr),
        .instReq    (instReq),
        .fetchValid (fetchValid),
        .fetchInst  (fetchInst),
        .fetchPc    (fetchPc)
    );

    decodeStage u_decode (
        .clk          (clk),
        .reset        (reset),
        .stall        (frontStall),
        .flushOut     (memStall),
        .fetchValid   (fetchValid),
        .fetchInst    (fetchInst),
        .fetchPc      (fetchPc),
        .opValue0     (opValue[0]),
        .opValue1     (opValue[1]),
        .opWait0      (opWait[0]),
        .opWait1      (opWait[1]),
        .readReg0     (readReg[0]),
        .readReg1     (readReg[1]),
        .needOp0      (needOp[0]),
        .needOp1      (needOp[1]),
        .redirect     (redirect),
        .redirectPc   (redirectPc),
        .decValid     (decValid),
        .decDest      (decDest),
        .decWbSrc     (decWbSrc),
        .decAluResult (decAluResult),
        .decMemAddr   (decMemAddr),
        .decStoreData (decStoreData),
        .decLoad      (decLoad),
        .decStore     (decStore),
        .decPc        (decPc)
    );

    regFile u_regs (
        .clk       (clk),
        .reset     (reset),
        .readReg0  (readReg[0]),
        .readReg1  (readReg[1]),
        .writeReg  (writeReg),
        .writeData (writeData),
        .writeEn   (writeEn),
        .readData0 (rfData[0]),
        .readData1 (rfData[1])
    );

    for (genvar i = 0; i < 2; i++) begin : gFwd
        operandForward u_fwd (
            .reqReg      (readReg[i]),
            .needed      (needOp[i]),
            .rfValue     (rfData[i]),
            .exeFwdValid (exeFwdValid),
            .exeFwdReg   (exeFwdReg),
            .exeFwdValue (exeFwdValue),
            .exeIsLoad   (exeIsLoad),
            .wbFwdValid  (wbFwdValid),
            .wbFwdReg    (wbFwdReg),
            .wbFwdValue  (wbFwdValue),
            .opValue     (opValue[i]),
            .opWait      (opWait[i])
        );
    end

    executeStage u_execute (
        .clk          (clk),
        .reset        (reset),
        .stall        (memStall),
        .decValid     (decValid),
        .decDest      (decDest),
        .decWbSrc     (decWbSrc),
        .decAluResult (decAluResult),
        .decMemAddr   (decMemAddr),
        .decStoreData (decStoreData),
        .decLoad      (decLoad),
        .decStore     (decStore),
        .decPc        (decPc),
        .dataRdata    (dataRdata),
        .dataValid    (dataValid),
        .dataAddr     (dataAddr),
        .dataRead     (dataRead),
        .dataWrite    (dataWrite),
        .dataWdata    (dataWdata),
        .memStall     (memStall),
        .exeFwdValid  (exeFwdValid),
        .exeFwdReg    (exeFwdReg),
        .exeFwdValue  (exeFwdValue),
        .exeIsLoad    (exeIsLoad),
        .exeValid     (exeValid),
        .exeDest      (exeDest),
        .exeWbSrc     (exeWbSrc),
        .exeAluResult (exeAluResult),
        .exePc        (exePc),
        .exeLoadData  (exeLoadData)
    );

    writebackStage u_writeback (
        .clk          (clk),
        .reset        (reset),
        .exeValid     (exeValid),
        .exeDest      (exeDest),
        .exeWbSrc     (exeWbSrc),
        .exeAluResult (exeAluResult),
        .exePc        (exePc),
        .exeLoadData  (exeLoadData),
        .writeReg     (writeReg),
        .writeData    (writeData),
        .writeEn      (writeEn),
        .wbFwdValid   (wbFwdValid),
        .wbFwdReg     (wbFwdReg),
        .wbFwdValue   (wbFwdValue),
        .wbPc         (wbPc),
        .wbWen        (wbWen),
        .wbWnum       (wbWnum),
        .wbWdata      (wbWdata)
    );

endmodule

/* verif/mipsCoreTb.sv */
`timescale 1ns/1ps

module mipsCoreTb import isaPkg::*;;

    logic    clk;
    logic    reset;
    word_t   instAddr;
    logic    instReq;
    word_t   instData;
    logic    instValid;
    word_t   dataAddr;
    logic    dataRead;
    logic    dataWrite;
    word_t   dataWdata;
    word_t   dataRdata;
    logic    dataValid;
    word_t   wbPc;
    logic    wbWen;
    regIdx_t wbWnum;
    word_t   wbWdata;

    word_t pat [256];
    word_t dmem [64];
    word_t rngState;
    int    instDelay;
    int    dataDelay;
    int    numWb;
    int    numStores;
    int    wbIdx;
    int    stIdx;
    int    traceErrors;
    int    storeErrors;
    int    resetErrors;
    int    tailErrors;
    bit    resetSeen;

    mipsCore #(.resetPc(32'h0)) u_dut (
        .clk(clk), .reset(reset),
        .instAddr(instAddr), .instReq(instReq), .instData(instData), .instValid(instValid),
        .dataAddr(dataAddr), .dataRead(dataRead), .dataWrite(dataWrite),
        .dataWdata(dataWdata), .dataRdata(dataRdata), .dataValid(dataValid),
        .wbPc(wbPc), .wbWen(wbWen), .wbWnum(wbWnum), .wbWdata(wbWdata)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Memory delay of 0 to 3 cycles
    function automatic int nextDelay();
        rngState = rngState * 32'd1103515245 + 32'd12345;
        return int'(rngState[17:16]);
    endfunction

    task automatic checkValue(input string name, input word_t expected, input word_t actual,
                              output bit ok);
        ok = 1'b1;
        assert (expected === actual) else begin
            $display("FAIL %0t %s expected %h actual %h", $time, name, expected, actual);
            ok = 1'b0;
        end
    endtask

    // Instruction and data memory models, both drawing delays in a fixed order
    always @(posedge clk) begin
        if (reset) begin
            instValid <= 1'b0;
            dataValid <= 1'b0;
        end else begin
            if (instValid) begin
                instValid <= 1'b0;
                instDelay = nextDelay();
            end else if (instReq) begin
                if (instDelay == 0) begin
                    instValid <= 1'b1;
                    instData  <= pat[instAddr[7:2] & 8'h3f];
                end else begin
                    instDelay--;
                end
            end

            // Store lands at the end of its valid cycle
            if (dataValid) begin
                dataValid <= 1'b0;
                dataDelay = nextDelay();
                if (dataWrite) begin
                    dmem[dataAddr[7:2]] <= dataWdata;
                end
            end else if (dataRead || dataWrite) begin
                if (dataDelay == 0) begin
                    dataValid <= 1'b1;
                    dataRdata <= dmem[dataAddr[7:2]];
                end else begin
                    dataDelay--;
                end
            end
        end
    end

    // Writeback trace and store checks
    always @(posedge clk) begin
        bit okPc;
        bit okNum;
        bit okData;
        bit okAddr;
        if (reset) begin
            // Outputs are unknown until the first reset edge
            if (resetSeen) begin
                assert (!wbWen && !dataRead && !dataWrite) else begin
                    $display("Register write or memory request seen during reset at %0t", $time);
                    resetErrors++;
                end
            end
            resetSeen = 1'b1;
        end else begin
            if (wbWen) begin
                assert (wbIdx < numWb) else begin
                    $display("Extra writeback at %0t to register %0d", $time, wbWnum);
                    tailErrors++;
                end
                if (wbIdx < numWb) begin
                    checkValue("wbPc", pat[96 + 3 * wbIdx], wbPc, okPc);
                    checkValue("wbWnum", pat[97 + 3 * wbIdx], word_t'(wbWnum), okNum);
                    checkValue("wbWdata", pat[98 + 3 * wbIdx], wbWdata, okData);
                    if (!(okPc && okNum && okData)) traceErrors++;
                    wbIdx++;
                end
            end
            if (dataWrite && dataValid) begin
                assert (stIdx < numStores) else begin
                    $display("Unexpected store at %0t to address %h", $time, dataAddr);
                    storeErrors++;
                end
                if (stIdx < numStores) begin
                    checkValue("dataAddr", pat[192 + 2 * stIdx], dataAddr, okAddr);
                    checkValue("dataWdata", pat[193 + 2 * stIdx], dataWdata, okData);
                    if (!(okAddr && okData)) storeErrors++;
                    stIdx++;
                end
            end
        end
    end

    initial begin
        int cycles;
        int limit;
        int failedTests;
        reset     = 1'b1;
        instValid = 1'b0;
        instData  = '0;
        dataValid = 1'b0;
        dataRdata = '0;
        rngState  = 32'hfb12;
        instDelay = 0;
        dataDelay = 0;
        resetSeen = 1'b0;
        wbIdx = 0;
        stIdx = 0;
        traceErrors = 0;
        storeErrors = 0;
        resetErrors = 0;
        tailErrors  = 0;
        failedTests = 0;
        foreach (pat[i]) pat[i] = '0;
        $readmemh("verif/mipsPatterns.txt", pat);
        numWb     = int'(pat[80]);
        numStores = int'(pat[81]);
        for (int i = 0; i < 64; i++) begin
            dmem[i] = (i < 16) ? pat[64 + i] : {8'hd0, 16'h0, 2'b0, i[5:0]};
        end
        limit = numWb * 30 + 200;

        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        $display("reset: %0d errors", resetErrors);
        if (resetErrors != 0) failedTests++;

        cycles = 0;
        while ((wbIdx < numWb || stIdx < numStores) && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (wbIdx < numWb || stIdx < numStores) begin
            $display("Timeout after %0d cycles with %0d of %0d writebacks and %0d of %0d stores",
                     cycles, wbIdx, numWb, stIdx, numStores);
            $display("Simulation failed");
            $finish;
        end else begin
            $display("writeback trace: %0d records, %0d errors", wbIdx, traceErrors);
            if (traceErrors != 0) failedTests++;
            $display("stores: %0d records, %0d errors", stIdx, storeErrors);
            if (storeErrors != 0) failedTests++;

            // Nothing may retire after the last record
            repeat (20) @(negedge clk);
            $display("quiet tail: %0d extra writebacks", tailErrors);
            if (tailErrors != 0) failedTests++;

            $display("tests run 4, passed %0d, failed %0d", 4 - failedTests, failedTests);
            if (failedTests == 0) begin
                $display("Simulation passed");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    end

endmodule

/* mipsLite.f */
hw/isaPkg.sv
hw/pipePkg.sv
hw/fetchUnit.sv
hw/decodeStage.sv
hw/regFile.sv
hw/operandForward.sv
hw/executeStage.sv
hw/writebackStage.sv
hw/mipsCore.sv
verif/mipsCoreTb.sv

/* Bender.yml */
package:
  name: mipsLite

sources:
  - files:
      - hw/isaPkg.sv
      - hw/pipePkg.sv
      - hw/fetchUnit.sv
      - hw/decodeStage.sv
      - hw/regFile.sv
      - hw/operandForward.sv
      - hw/executeStage.sv
      - hw/writebackStage.sv
      - hw/mipsCore.sv
  - target: simulation
    files:
      - verif/mipsCoreTb.sv

/* verif/mipsPatterns.txt */
// Word image. @000 program, @040 data words, @050 counts (writebacks, stores),
// @060 writeback records (pc, reg, value), @0C0 store records (addr, value)
@000
3C011234 34215678 24020010 2403FFFD
00432021 00432823 00243024 00C53825
0062402A 8C490000 01215021 AC4A0004
8C4B0004 25600001 00006021 10420003
240D0001 240E0BAD 240E0BAD 14420002
240F0002 14430003 24100003 240E0BAD
240E0BAD 10430005 24110004 0C000020
24120005 AC530008 0800001E 00000000
27F30100 03E00008 24140006
@040
11111111 22222222 33333333 44444444
CAFEF00D 55555555 66666666 77777777
@050
00000015 00000002
@060
00000000 00000001 12340000  00000004 00000001 12345678
00000008 00000002 00000010  0000000C 00000003 FFFFFFFD
00000010 00000004 0000000D  00000014 00000005 00000013
00000018 00000006 00000008  0000001C 00000007 0000001B
00000020 00000008 00000001  00000024 00000009 CAFEF00D
00000028 0000000A DD334685  00000030 0000000B DD334685
00000038 0000000C 00000000  00000040 0000000D 00000001
00000050 0000000F 00000002  00000058 00000010 00000003
00000068 00000011 00000004  0000006C 0000001F 00000074
00000070 00000012 00000005  00000080 00000013 00000174
00000088 00000014 00000006
@0C0
00000014 DD334685  00000018 00000174
